/* Bender.yml */
package:
  name: commit_tracer

sources:
  # Packages first, then the design bottom up
  - riscv_pkg.sv
  - trace_pkg.sv
  - commit_trace_port.sv
  - pc_fifo.sv
  - pc_rr_arbiter.sv
  - commit_tracer.sv

  - target: simulation
    files:
      - tb_commit_tracer.sv

/* commit_trace_port.sv */
// Trace record formatter for all commit ports
// Classifies each commit as retired, exception or interrupt
// and registers the record together with the execution mode

module commit_trace_port (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  // Commit side
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                  commit_ack_i,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                  commit_ex_valid_i,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::VLEN-1:0] commit_pc_i,
  input  riscv_pkg::cause_u [trace_pkg::NR_COMMIT_PORTS-1:0]     commit_cause_i,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::XLEN-1:0] commit_tval_i,
  input  logic [riscv_pkg::PRIV_W-1:0]                           priv_lvl_i,
  input  logic                                                   debug_mode_i,
  // Trace records
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0]                  trace_valid_o,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0]                  trace_exception_o,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0]                  trace_interrupt_o,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::VLEN-1:0] trace_iaddr_o,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::INSN_W-1:0] trace_insn_o,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::XLEN-1:0] trace_cause_o,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::XLEN-1:0] trace_tval_o,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::MODE_W-1:0] trace_mode_o
);

  import riscv_pkg::*;
  import trace_pkg::*;

  logic [MODE_W-1:0]                          mode_d;
  logic [NR_COMMIT_PORTS-1:0]                 valid_q;
  logic [NR_COMMIT_PORTS-1:0]                 exception_q;
  logic [NR_COMMIT_PORTS-1:0]                 interrupt_q;
  logic [NR_COMMIT_PORTS-1:0][VLEN-1:0]       iaddr_q;
  logic [NR_COMMIT_PORTS-1:0][INSN_W-1:0]     insn_q;
  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]       cause_q;
  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]       tval_q;
  logic [NR_COMMIT_PORTS-1:0][MODE_W-1:0]     mode_q;

  // ------------------------------
  // Execution mode
  // ------------------------------
  always_comb begin
    if (debug_mode_i) begin
      mode_d = MODE_D;
    end else begin
      case (priv_lvl_i)
        PRIV_LVL_U: mode_d = MODE_U;
        PRIV_LVL_S: mode_d = MODE_S;
        // Reserved level 2 is reported as machine mode
        default:    mode_d = MODE_M;
      endcase
    end
  end

  // ------------------------------
  // Classification
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q     <= '0;
      exception_q <= '0;
      interrupt_q <= '0;
    end else begin
      for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
        valid_q[i]     <= commit_ack_i[i] & ~commit_ex_valid_i[i];
        exception_q[i] <= commit_ack_i[i] & commit_ex_valid_i[i] &
                          ~commit_cause_i[i].fields.irq;
        interrupt_q[i] <= commit_ack_i[i] & commit_ex_valid_i[i] &
                          commit_cause_i[i].fields.irq;
      end
    end
  end

  // Record payload, qualified by the flags above
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
      iaddr_q[i] <= commit_pc_i[i];
      insn_q[i]  <= commit_tval_i[i][INSN_W-1:0];
      cause_q[i] <= commit_cause_i[i].raw;
      tval_q[i]  <= commit_tval_i[i];
      mode_q[i]  <= mode_d;
    end
  end

  assign trace_valid_o     = valid_q;
  assign trace_exception_o = exception_q;
  assign trace_interrupt_o = interrupt_q;
  assign trace_iaddr_o     = iaddr_q;
  assign trace_insn_o      = insn_q;
  assign trace_cause_o     = cause_q;
  assign trace_tval_o      = tval_q;
  assign trace_mode_o      = mode_q;

  // ------------------------------
  // Checks
  // ------------------------------
  for (genvar i = 0; i < NR_COMMIT_PORTS; i++) begin : gen_chk
    // One record kind per port
    a_one_kind: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0({valid_q[i], exception_q[i], interrupt_q[i]}));
  end

endmodule

/* commit_tracer.sv */
// Commit trace unit top level
// Trace record formatter, one PC queue per commit port
// and the round-robin merge into a single PC stream

module commit_tracer (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  // Commit side
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                  commit_ack_i,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                  commit_ex_valid_i,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::VLEN-1:0] commit_pc_i,
  input  riscv_pkg::cause_u [trace_pkg::NR_COMMIT_PORTS-1:0]     commit_cause_i,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::XLEN-1:0] commit_tval_i,
  input  logic [riscv_pkg::PRIV_W-1:0]                           priv_lvl_i,
  input  logic                                                   debug_mode_i,
  // Trace records
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0]                  trace_valid_o,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0]                  trace_exception_o,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0]                  trace_interrupt_o,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::VLEN-1:0] trace_iaddr_o,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::INSN_W-1:0] trace_insn_o,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::XLEN-1:0] trace_cause_o,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::XLEN-1:0] trace_tval_o,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::MODE_W-1:0] trace_mode_o,
  // Merged PC stream
  output logic                                                   pc_valid_o,
  output logic [riscv_pkg::VLEN-1:0]                             pc_o,
  output logic [trace_pkg::PORT_IDX_W-1:0]                       pc_port_o
);

  import riscv_pkg::*;
  import trace_pkg::*;

  logic [NR_COMMIT_PORTS-1:0]           push;
  logic [NR_COMMIT_PORTS-1:0]           fifo_empty;
  logic [NR_COMMIT_PORTS-1:0]           fifo_pop;
  logic [NR_COMMIT_PORTS-1:0][VLEN-1:0] fifo_head;

  // ------------------------------
  // Trace records
  // ------------------------------
  commit_trace_port i_trace_port (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .commit_ack_i      ( commit_ack_i      ),
    .commit_ex_valid_i ( commit_ex_valid_i ),
    .commit_pc_i       ( commit_pc_i       ),
    .commit_cause_i    ( commit_cause_i    ),
    .commit_tval_i     ( commit_tval_i     ),
    .priv_lvl_i        ( priv_lvl_i        ),
    .debug_mode_i      ( debug_mode_i      ),
    .trace_valid_o     ( trace_valid_o     ),
    .trace_exception_o ( trace_exception_o ),
    .trace_interrupt_o ( trace_interrupt_o ),
    .trace_iaddr_o     ( trace_iaddr_o     ),
    .trace_insn_o      ( trace_insn_o      ),
    .trace_cause_o     ( trace_cause_o     ),
    .trace_tval_o      ( trace_tval_o      ),
    .trace_mode_o      ( trace_mode_o      )
  );

  // ------------------------------
  // PC queues
  // ------------------------------
  // Only retired instructions enter the stream
  assign push = commit_ack_i & ~commit_ex_valid_i;

  for (genvar i = 0; i < NR_COMMIT_PORTS; i++) begin : gen_pc_fifo
    pc_fifo i_pc_fifo (
      .clk_i   ( clk_i          ),
      .rst_ni  ( rst_ni         ),
      .push_i  ( push[i]        ),
      .data_i  ( commit_pc_i[i] ),
      .pop_i   ( fifo_pop[i]    ),
      .data_o  ( fifo_head[i]   ),
      .empty_o ( fifo_empty[i]  ),
      .full_o  (                )
    );
  end

  // ------------------------------
  // Merge
  // ------------------------------
  pc_rr_arbiter i_rr_arbiter (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .empty_i    ( fifo_empty ),
    .head_i     ( fifo_head  ),
    .pop_o      ( fifo_pop   ),
    .pc_valid_o ( pc_valid_o ),
    .pc_o       ( pc_o       ),
    .pc_port_o  ( pc_port_o  )
  );

endmodule

/* flist.f */
riscv_pkg.sv
trace_pkg.sv
commit_trace_port.sv
pc_fifo.sv
pc_rr_arbiter.sv
commit_tracer.sv
tb_commit_tracer.sv

/* pc_fifo.sv */
// Per-port queue of retired PCs
// Circular buffer with read/write pointers and an occupancy count,
// a push into a full buffer is dropped

module pc_fifo (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       push_i,
  input  logic [riscv_pkg::VLEN-1:0] data_i,
  input  logic                       pop_i,
  output logic [riscv_pkg::VLEN-1:0] data_o,
  output logic                       empty_o,
  output logic                       full_o
);

  import riscv_pkg::*;
  import trace_pkg::*;

  logic [VLEN-1:0]  mem_q [PC_QUEUE_DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             do_push;
  logic             do_pop;

  // Pointer advance with wrap at the last entry
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (ptr == PTR_W'(PC_QUEUE_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // ------------------------------
  // Status
  // ------------------------------
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == (PTR_W+1)'(PC_QUEUE_DEPTH));

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;

  // Head is read straight from storage
  assign data_o = mem_q[rd_ptr_q];

  // ------------------------------
  // Pointers and count
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------
  // Commit traffic must stay below the drain rate
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(push_i && full_o));

  // The arbiter only pops a queue it saw holding an entry
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(pop_i && empty_o));

endmodule

/* pc_rr_arbiter.sv */
// Round-robin merge of the per-port PC queues
// Grants one non-empty queue per cycle, pops it, and registers
// the head PC with the index of its port

module pc_rr_arbiter (
  input  logic                                                   clk_i,
  input  logic                                                   rst_ni,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0]                  empty_i,
  input  logic [trace_pkg::NR_COMMIT_PORTS-1:0][riscv_pkg::VLEN-1:0] head_i,
  output logic [trace_pkg::NR_COMMIT_PORTS-1:0]                  pop_o,
  output logic                                                   pc_valid_o,
  output logic [riscv_pkg::VLEN-1:0]                             pc_o,
  output logic [trace_pkg::PORT_IDX_W-1:0]                       pc_port_o
);

  import riscv_pkg::*;
  import trace_pkg::*;

  // Port that is searched first, the one after the last grant
  logic [PORT_IDX_W-1:0] rr_q;
  logic                  gnt_valid;
  logic [PORT_IDX_W-1:0] gnt_idx;
  logic                  pc_valid_q;
  logic [VLEN-1:0]       pc_q;
  logic [PORT_IDX_W-1:0] port_q;

  // ------------------------------
  // Grant
  // ------------------------------
  always_comb begin
    int unsigned cand;
    cand      = 0;
    gnt_valid = 1'b0;
    gnt_idx   = '0;
    for (int unsigned k = 0; k < NR_COMMIT_PORTS; k++) begin
      cand = rr_q + k;
      if (cand >= NR_COMMIT_PORTS) begin
        cand = cand - NR_COMMIT_PORTS;
      end
      if (!gnt_valid && !empty_i[cand]) begin
        gnt_valid = 1'b1;
        gnt_idx   = PORT_IDX_W'(cand);
      end
    end
  end

  // Pop the granted queue in the same cycle
  always_comb begin
    pop_o          = '0;
    pop_o[gnt_idx] = gnt_valid;
  end

  // ------------------------------
  // Pointer and output stage
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q       <= '0;
      pc_valid_q <= 1'b0;
    end else begin
      pc_valid_q <= gnt_valid;
      if (gnt_valid) begin
        if (gnt_idx == PORT_IDX_W'(NR_COMMIT_PORTS - 1)) begin
          rr_q <= '0;
        end else begin
          rr_q <= gnt_idx + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_valid) begin
      pc_q   <= head_i[gnt_idx];
      port_q <= gnt_idx;
    end
  end

  assign pc_valid_o = pc_valid_q;
  assign pc_o       = pc_q;
  assign pc_port_o  = port_q;

  // ------------------------------
  // Checks
  // ------------------------------
  a_pop_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(pop_o));

  a_pop_nonempty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pop_o & empty_i) == '0);

endmodule

/* riscv_pkg.sv */
// Architectural definitions for the commit trace unit
// Word and address widths, privilege codes, trace mode codes
// and the cause word with its interrupt/code view

package riscv_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  localparam int unsigned XLEN   = 64;
  localparam int unsigned VLEN   = 64;
  localparam int unsigned INSN_W = 32;

  // ------------------------------
  // Privilege levels
  // ------------------------------
  localparam int unsigned PRIV_W = 2;

  localparam logic [PRIV_W-1:0] PRIV_LVL_U = 2'd0;
  localparam logic [PRIV_W-1:0] PRIV_LVL_S = 2'd1;
  localparam logic [PRIV_W-1:0] PRIV_LVL_M = 2'd3;

  // ------------------------------
  // Trace mode codes
  // ------------------------------
  // Debug mode overrides the privilege level in the trace
  localparam int unsigned MODE_W = 2;

  localparam logic [MODE_W-1:0] MODE_U = 2'd0;
  localparam logic [MODE_W-1:0] MODE_S = 2'd1;
  localparam logic [MODE_W-1:0] MODE_M = 2'd2;
  localparam logic [MODE_W-1:0] MODE_D = 2'd3;

  // ------------------------------
  // Cause word
  // ------------------------------
  // Top bit set means interrupt, otherwise synchronous exception
  typedef union packed {
    logic [XLEN-1:0] raw;
    struct packed {
      logic            irq;
      logic [XLEN-2:0] code;
    } fields;
  } cause_u;

endpackage

/* tb_commit_tracer.sv */
// Testbench for the commit trace unit
// LFSR driven commit traffic, a reference model of the trace records,
// the PC queues and the round-robin merge, with checks on every cycle

module tb_commit_tracer;

  import riscv_pkg::*;
  import trace_pkg::*;

  localparam int unsigned NUM_CYCLES    = 2000;
  localparam int unsigned DRAIN_TIMEOUT = 50;

  logic                                 clk;
  logic                                 rst_n;
  logic [NR_COMMIT_PORTS-1:0]           commit_ack;
  logic [NR_COMMIT_PORTS-1:0]           commit_ex_valid;
  logic [NR_COMMIT_PORTS-1:0][VLEN-1:0] commit_pc;
  cause_u [NR_COMMIT_PORTS-1:0]         commit_cause;
  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0] commit_tval;
  logic [PRIV_W-1:0]                    priv_lvl;
  logic                                 debug_mode;

  logic [NR_COMMIT_PORTS-1:0]             trace_valid;
  logic [NR_COMMIT_PORTS-1:0]             trace_exception;
  logic [NR_COMMIT_PORTS-1:0]             trace_interrupt;
  logic [NR_COMMIT_PORTS-1:0][VLEN-1:0]   trace_iaddr;
  logic [NR_COMMIT_PORTS-1:0][INSN_W-1:0] trace_insn;
  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]   trace_cause;
  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]   trace_tval;
  logic [NR_COMMIT_PORTS-1:0][MODE_W-1:0] trace_mode;
  logic                                   pc_valid;
  logic [VLEN-1:0]                        pc;
  logic [PORT_IDX_W-1:0]                  pc_port;

  // Reference model state
  logic [NR_COMMIT_PORTS-1:0]             exp_valid;
  logic [NR_COMMIT_PORTS-1:0]             exp_exc;
  logic [NR_COMMIT_PORTS-1:0]             exp_irq;
  logic [NR_COMMIT_PORTS-1:0][VLEN-1:0]   exp_iaddr;
  logic [NR_COMMIT_PORTS-1:0][INSN_W-1:0] exp_insn;
  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]   exp_cause;
  logic [NR_COMMIT_PORTS-1:0][XLEN-1:0]   exp_tval;
  logic [MODE_W-1:0]                      exp_mode;
  logic                                   exp_pc_valid;
  logic [VLEN-1:0]                        exp_pc;
  logic [PORT_IDX_W-1:0]                  exp_port;
  logic [VLEN-1:0]                        model_q [NR_COMMIT_PORTS][$];
  int                                     rr_model;

  logic [31:0]                lfsr_q;
  logic [NR_COMMIT_PORTS-1:0] retired_last;
  int                         mismatches;
  int                         other_fails;
  int                         retired_count;
  int                         pcs_out;
  int                         drain_cycles;

  commit_tracer i_dut (
    .clk_i             ( clk             ),
    .rst_ni            ( rst_n           ),
    .commit_ack_i      ( commit_ack      ),
    .commit_ex_valid_i ( commit_ex_valid ),
    .commit_pc_i       ( commit_pc       ),
    .commit_cause_i    ( commit_cause    ),
    .commit_tval_i     ( commit_tval     ),
    .priv_lvl_i        ( priv_lvl        ),
    .debug_mode_i      ( debug_mode      ),
    .trace_valid_o     ( trace_valid     ),
    .trace_exception_o ( trace_exception ),
    .trace_interrupt_o ( trace_interrupt ),
    .trace_iaddr_o     ( trace_iaddr     ),
    .trace_insn_o      ( trace_insn      ),
    .trace_cause_o     ( trace_cause     ),
    .trace_tval_o      ( trace_tval      ),
    .trace_mode_o      ( trace_mode      ),
    .pc_valid_o        ( pc_valid        ),
    .pc_o              ( pc              ),
    .pc_port_o         ( pc_port         )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------
  // Random source
  // ------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[62:0], lfsr_q[0]};
    end
    return v;
  endfunction

  function automatic logic [MODE_W-1:0] expected_mode(input logic [PRIV_W-1:0] lvl,
                                                      input logic dbg);
    if (dbg) begin
      return MODE_D;
    end
    case (lvl)
      PRIV_LVL_U: return MODE_U;
      PRIV_LVL_S: return MODE_S;
      default:    return MODE_M;
    endcase
  endfunction

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic drive_random();
    logic [NR_COMMIT_PORTS-1:0] retire_now;
    logic [63:0]                lvl;
    logic                       a;
    logic                       e;
    retire_now = '0;
    for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
      a = (take_bits(2) != 64'd0);
      e = (take_bits(2) == 64'd0);
      // No back-to-back retires on one port, keeps queues below full
      if (a && !e && retired_last[i]) begin
        a = 1'b0;
      end
      retire_now[i]          = a & ~e;
      commit_ack[i]          <= a;
      commit_ex_valid[i]     <= e;
      commit_pc[i]           <= take_bits(62) << 2;
      commit_tval[i]         <= take_bits(64);
      commit_cause[i].raw    <= (take_bits(1) << 63) | take_bits(5);
    end
    retired_last = retire_now;
    lvl = take_bits(2);
    priv_lvl   <= (lvl[1:0] == 2'd1) ? PRIV_LVL_S :
                  (lvl[1:0] == 2'd0) ? PRIV_LVL_U : PRIV_LVL_M;
    debug_mode <= (take_bits(3) == 64'd0);
  endtask

  task automatic drive_idle();
    commit_ack   <= '0;
    retired_last = '0;
  endtask

  // ------------------------------
  // Reference model
  // ------------------------------
  // Called at the rising edge, reads the inputs the DUT samples there
  task automatic model_update();
    int g;
    exp_mode = expected_mode(priv_lvl, debug_mode);
    for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
      exp_valid[i] = commit_ack[i] & ~commit_ex_valid[i];
      exp_exc[i]   = commit_ack[i] & commit_ex_valid[i] & ~commit_cause[i].fields.irq;
      exp_irq[i]   = commit_ack[i] & commit_ex_valid[i] & commit_cause[i].fields.irq;
      exp_iaddr[i] = commit_pc[i];
      exp_insn[i]  = commit_tval[i][INSN_W-1:0];
      exp_cause[i] = commit_cause[i].raw;
      exp_tval[i]  = commit_tval[i];
    end
    // Grant from the queue contents of the cycle that just ended
    g = -1;
    for (int k = 0; k < NR_COMMIT_PORTS; k++) begin
      if (g < 0 && model_q[(rr_model + k) % NR_COMMIT_PORTS].size() > 0) begin
        g = (rr_model + k) % NR_COMMIT_PORTS;
      end
    end
    exp_pc_valid = (g >= 0);
    if (g >= 0) begin
      exp_pc   = model_q[g].pop_front();
      exp_port = PORT_IDX_W'(g);
      rr_model = (g + 1) % NR_COMMIT_PORTS;
    end
    // Retired PCs become visible after this edge
    for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
      if (commit_ack[i] && !commit_ex_valid[i]) begin
        model_q[i].push_back(commit_pc[i]);
        retired_count++;
      end
    end
  endtask

  // ------------------------------
  // Checks
  // ------------------------------
  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    assert (got === exp) else begin
      mismatches++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_outputs();
    for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
      check_val($sformatf("trace_valid_o[%0d]", i), 64'(trace_valid[i]), 64'(exp_valid[i]));
      check_val($sformatf("trace_exception_o[%0d]", i), 64'(trace_exception[i]),
                64'(exp_exc[i]));
      check_val($sformatf("trace_interrupt_o[%0d]", i), 64'(trace_interrupt[i]),
                64'(exp_irq[i]));
      if (exp_valid[i] || exp_exc[i] || exp_irq[i]) begin
        check_val($sformatf("trace_iaddr_o[%0d]", i), trace_iaddr[i], exp_iaddr[i]);
        check_val($sformatf("trace_insn_o[%0d]", i), 64'(trace_insn[i]), 64'(exp_insn[i]));
        check_val($sformatf("trace_cause_o[%0d]", i), trace_cause[i], exp_cause[i]);
        check_val($sformatf("trace_tval_o[%0d]", i), trace_tval[i], exp_tval[i]);
        check_val($sformatf("trace_mode_o[%0d]", i), 64'(trace_mode[i]), 64'(exp_mode));
      end
    end
    check_val("pc_valid_o", 64'(pc_valid), 64'(exp_pc_valid));
    if (exp_pc_valid && pc_valid) begin
      check_val("pc_o", pc, exp_pc);
      check_val("pc_port_o", 64'(pc_port), 64'(exp_port));
      pcs_out++;
    end
  endtask

  task automatic step_cycle(input logic gen);
    @(posedge clk);
    model_update();
    if (gen) begin
      drive_random();
    end else begin
      drive_idle();
    end
    @(negedge clk);
    check_outputs();
  endtask

  function automatic logic stream_drained();
    logic busy;
    busy = exp_pc_valid | (|commit_ack);
    for (int i = 0; i < NR_COMMIT_PORTS; i++) begin
      busy = busy | (model_q[i].size() > 0);
    end
    return !busy;
  endfunction

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    lfsr_q          = 32'h38aac640;
    rst_n           = 1'b0;
    commit_ack      = '0;
    commit_ex_valid = '0;
    commit_pc       = '0;
    commit_cause    = '0;
    commit_tval     = '0;
    priv_lvl        = PRIV_LVL_M;
    debug_mode      = 1'b0;
    exp_valid       = '0;
    exp_exc         = '0;
    exp_irq         = '0;
    exp_pc_valid    = 1'b0;
    rr_model        = 0;
    retired_last    = '0;
    mismatches      = 0;
    other_fails     = 0;
    retired_count   = 0;
    pcs_out         = 0;

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // Quiet after reset, all flags low
    repeat (4) step_cycle(1'b0);

    for (int n = 0; n < NUM_CYCLES; n++) begin
      step_cycle(1'b1);
    end

    drain_cycles = 0;
    step_cycle(1'b0);
    while (!stream_drained() && drain_cycles < DRAIN_TIMEOUT) begin
      step_cycle(1'b0);
      drain_cycles++;
    end
    if (!stream_drained()) begin
      other_fails++;
      $display("PC stream did not drain within %0d cycles", DRAIN_TIMEOUT);
    end

    assert (pcs_out == retired_count) else begin
      mismatches++;
      $display("mismatch pc count: got %h expected %h", pcs_out, retired_count);
    end

    $display("Errors: %0d mismatches, %0d other failures (%0d PCs checked)",
             mismatches, other_fails, pcs_out);
    if (mismatches == 0 && other_fails == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* trace_pkg.sv */
// Trace unit configuration
// Commit port count, PC queue depth and the derived index widths

package trace_pkg;

  // ------------------------------
  // Commit ports
  // ------------------------------
  localparam int unsigned NR_COMMIT_PORTS = 2;

  // Index of the port a PC came from
  localparam int unsigned PORT_IDX_W = (NR_COMMIT_PORTS > 1) ? $clog2(NR_COMMIT_PORTS) : 1;

  // ------------------------------
  // PC queues
  // ------------------------------
  // Entries per commit port
  localparam int unsigned PC_QUEUE_DEPTH = 4;

  // Read and write pointer width
  localparam int unsigned PTR_W = (PC_QUEUE_DEPTH > 1) ? $clog2(PC_QUEUE_DEPTH) : 1;

endpackage
